// ==== design/addMod2Nm1.sv ====
`timescale 1ns/1ps

// ones' complement adder, s = a + b mod (2**width - 1), double zero
module addMod2Nm1 #(
	parameter int width = 16, // word width, 2 or more
	parameter int speed = 2   // prefix network choice
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic [width-1:0] s
);

	logic [width-1:0] bitGen;   // a & b
	logic [width-1:0] bitProp;  // a | b, enough for carries
	logic [width-1:0] halfSum;  // a ^ b
	logic [width-1:0] grpGen;   // prefix generate, no carry in
	logic [width-1:0] grpProp;  // prefix propagate
	logic [width-2:0] carry;    // carries into bits 1..width-1
	logic             carryIn;  // end-around carry

	assign bitGen  = a & b;
	assign bitProp = a | b;
	assign halfSum = a ^ b;

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix (
		.GI(bitGen),
		.PI(bitProp),
		.GO(grpGen),
		.PO(grpProp)
	);

	// carry out of the top wraps back in as bit 0 carry
	// all-propagate with no generate gives no wrap, so ffff stays ffff
	assign carryIn = grpGen[width-1];

	// extra prefix level folding the carry in
	assign carry = grpGen[width-2:0] | (grpProp[width-2:0] & {(width-1){carryIn}});

	assign s = halfSum ^ {carry, carryIn};

endmodule

// ==== design/checksumCombiner.sv ====
`timescale 1ns/1ps

module checksumCombiner (
	input  logic          clk,
	input  logic          arstN,
	input  logic          packetDone, // last word going into a lane now
	input  logic          sumAck,     // four-phase ack from sink
	input  csumPkg::wordT evenSum,
	input  csumPkg::wordT oddSum,
	output logic          sumReq,
	output logic          busy,       // hold off the next packet
	output logic          laneClear,  // zero both lanes at handoff
	output csumPkg::wordT sumData
);

	import csumPkg::*;

	wordT laneTotal;  // even + odd, end-around carry
	logic sumPending; // lanes settle this cycle, result next edge
	logic ackWait;    // waiting for sumAck to drop

	addMod2Nm1 #(
		.width(wordWidth),
		.speed(prefixSpeed)
	) laneAdder (
		.a(evenSum),
		.b(oddSum),
		.s(laneTotal)
	);

	assign laneClear = sumReq && sumAck; // same edge that drops sumReq

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			sumPending <= 1'b0;
			sumReq     <= 1'b0;
			ackWait    <= 1'b0;
			busy       <= 1'b0;
		end else begin
			sumPending <= packetDone;
			if (packetDone) begin
				busy <= 1'b1;
			end
			if (sumPending) begin
				sumReq <= 1'b1; // sumData loads on this edge too
			end else if (sumReq && sumAck) begin
				sumReq  <= 1'b0;
				ackWait <= 1'b1;
			end
			// last phase of the handshake frees the intake
			if (ackWait && !sumAck) begin
				ackWait <= 1'b0;
				busy    <= 1'b0;
			end
		end
	end

	// result register, held stable for the whole handshake
	always_ff @(posedge clk) begin
		if (sumPending) begin
			sumData <= ~laneTotal;
		end
	end

endmodule

// ==== design/checksumEngine.sv ====
`timescale 1ns/1ps

module checksumEngine (
	input  logic          clk,
	input  logic          arstN,
	input  logic          wordReq,  // word channel
	input  logic          wordLast,
	input  csumPkg::wordT wordData,
	output logic          wordAck,
	output logic          sumReq,   // checksum channel
	output csumPkg::wordT sumData,
	input  logic          sumAck
);

	import csumPkg::*;

	logic evenEn;
	logic oddEn;
	logic packetDone;
	logic laneClear;
	logic busy;
	wordT evenSum; // words 0, 2, 4 ...
	wordT oddSum;  // words 1, 3, 5 ...

	wordIntake intake (
		.clk       (clk),
		.arstN     (arstN),
		.wordReq   (wordReq),
		.wordLast  (wordLast),
		.busy      (busy),
		.wordAck   (wordAck),
		.evenEn    (evenEn),
		.oddEn     (oddEn),
		.packetDone(packetDone)
	);

	// both lanes see every word, the enables pick one
	laneAccumulator evenLane (
		.clk  (clk),
		.arstN(arstN),
		.en   (evenEn),
		.clear(laneClear),
		.word (wordData),
		.sum  (evenSum)
	);

	laneAccumulator oddLane (
		.clk  (clk),
		.arstN(arstN),
		.en   (oddEn),
		.clear(laneClear),
		.word (wordData),
		.sum  (oddSum)
	);

	checksumCombiner combiner (
		.clk       (clk),
		.arstN     (arstN),
		.packetDone(packetDone),
		.sumAck    (sumAck),
		.evenSum   (evenSum),
		.oddSum    (oddSum),
		.sumReq    (sumReq),
		.busy      (busy),
		.laneClear (laneClear),
		.sumData   (sumData)
	);

endmodule

// ==== design/csumPkg.sv ====
package csumPkg;

	// checksum word, one internet-style 16 bit word
	localparam int wordWidth = 16;

	// prefix network choice for every modulo adder
	// 0 serial, 1 brent-kung, 2 sklansky
	localparam int prefixSpeed = 2;

	// data words, lane sums and the final checksum
	typedef logic [wordWidth-1:0] wordT;

	// word intake handshake
	typedef enum logic [1:0] {
		sIdle,    // waiting for wordReq
		sAckHigh, // ack raised, waiting for req to drop
		sHold     // combiner busy, next packet waits
	} intakeStateT;

endpackage

// ==== design/laneAccumulator.sv ====
`timescale 1ns/1ps

module laneAccumulator (
	input  logic          clk,
	input  logic          arstN,
	input  logic          en,    // word routed to this lane
	input  logic          clear, // packet handed off, start over
	input  csumPkg::wordT word,
	output csumPkg::wordT sum    // running ones' complement sum
);

	import csumPkg::*;

	wordT nextSum;

	addMod2Nm1 #(
		.width(wordWidth),
		.speed(prefixSpeed)
	) adder (
		.a(sum),
		.b(word),
		.s(nextSum)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			sum <= '0;
		end else if (clear) begin
			sum <= '0; // clear beats en
		end else if (en) begin
			sum <= nextSum;
		end
	end

endmodule

// ==== design/prefixAndOr.sv ====
`timescale 1ns/1ps

module prefixAndOr #(
	parameter int width = 16, // operand width, 2 or more
	parameter int speed = 2   // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] GI, // bit generate
	input  logic [width-1:0] PI, // bit propagate
	output logic [width-1:0] GO, // generate of bits j..0
	output logic [width-1:0] PO  // propagate of bits j..0
);

	localparam int n = width;
	localparam int m = $clog2(width); // tree depth

	if (speed == 2) begin : gSklansky
		logic [m:0][n-1:0] gt, pt; // row per level, row 0 is the input

		assign gt[0] = GI;
		assign pt[0] = PI;

		for (genvar l = 1; l <= m; l++) begin : gLevel
			for (genvar j = 0; j < n; j++) begin : gBit
				// upper half of each 2**l block pulls from top of lower half
				if ((j / 2**(l-1)) % 2 == 1) begin : gBlack
					localparam int src = (j / 2**(l-1)) * 2**(l-1) - 1;
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][src]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][src];
				end else begin : gWhite
					assign gt[l][j] = gt[l-1][j]; // pass through
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		assign GO = gt[m];
		assign PO = pt[m];
	end else if (speed == 1) begin : gBrentKung
		localparam int last = 2*m - 1; // up sweep m levels, down sweep m-1
		logic [last:0][n-1:0] gt, pt;

		assign gt[0] = GI;
		assign pt[0] = PI;

		// up sweep, top bit of each 2**l block
		for (genvar l = 1; l <= m; l++) begin : gUp
			for (genvar j = 0; j < n; j++) begin : gBit
				if ((j + 1) % 2**l == 0) begin : gBlack
					localparam int src = j - 2**(l-1);
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][src]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][src];
				end else begin : gWhite
					assign gt[l][j] = gt[l-1][j];
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		// down sweep fills the middle of each block from the block below
		for (genvar l = m + 1; l <= last; l++) begin : gDown
			for (genvar j = 0; j < n; j++) begin : gBit
				localparam int d = 2*m - l;
				if (((j + 1) % 2**d == 2**(d-1)) && (j >= 2**d)) begin : gBlack
					localparam int src = j - 2**(d-1);
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][src]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][src];
				end else begin : gWhite
					assign gt[l][j] = gt[l-1][j];
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		assign GO = gt[last];
		assign PO = pt[last];
	end else begin : gSerial
		logic [n-1:0] gt, pt; // ripple chain, smallest and slowest

		assign gt[0] = GI[0];
		assign pt[0] = PI[0];

		for (genvar j = 1; j < n; j++) begin : gBit
			assign gt[j] = GI[j] | (PI[j] & gt[j-1]);
			assign pt[j] = PI[j] & pt[j-1];
		end

		assign GO = gt;
		assign PO = pt;
	end

endmodule

// ==== design/wordIntake.sv ====
`timescale 1ns/1ps

module wordIntake (
	input  logic clk,
	input  logic arstN,
	input  logic wordReq,    // four-phase request from source
	input  logic wordLast,   // flags final word of packet
	input  logic busy,       // combiner still handing off a checksum
	output logic wordAck,
	output logic evenEn,     // one-cycle pulse, word to even lane
	output logic oddEn,      // one-cycle pulse, word to odd lane
	output logic packetDone  // one-cycle pulse with the last word
);

	import csumPkg::*;

	intakeStateT state;
	intakeStateT nextState;
	logic        oddSel; // lane for next word, low = even
	logic        accept; // word taken this cycle

	// take a word only from idle and only while combiner is free
	assign accept = (state == sIdle) && wordReq && !busy;

	assign evenEn     = accept && !oddSel;
	assign oddEn      = accept && oddSel;
	assign packetDone = accept && wordLast;

	assign wordAck = (state == sAckHigh); // ack held until req drops

	always_comb begin
		nextState = state;
		case (state)
			sIdle: begin
				if (wordReq) begin
					nextState = busy ? sHold : sAckHigh;
				end
			end
			sAckHigh: begin
				if (!wordReq) begin
					nextState = sIdle; // ack falls next edge
				end
			end
			sHold: begin
				if (!busy) begin
					nextState = sIdle; // retry from idle
				end
			end
			default: nextState = sIdle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state  <= sIdle;
			oddSel <= 1'b0; // first word goes even
		end else begin
			state <= nextState;
			if (accept) begin
				// alternate lanes, restart at even for the next packet
				oddSel <= wordLast ? 1'b0 : !oddSel;
			end
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the checksum engine testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f src.f --top-module tbChecksumEngine \
	--Mdir obj_dir -o simChecksumEngine

./obj_dir/simChecksumEngine > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
grep -q "TESTS PASSED" sim.log

// ==== src.f ====
design/csumPkg.sv
design/prefixAndOr.sv
design/addMod2Nm1.sv
design/wordIntake.sv
design/laneAccumulator.sv
design/checksumCombiner.sv
design/checksumEngine.sv
tests/tbChecksumEngine.sv

// ==== tests/tbChecksumEngine.sv ====
`timescale 1ns/1ps

module tbChecksumEngine;

	import csumPkg::*;

	localparam int randPackets  = 24;
	localparam int totalPackets = randPackets + 3; // three directed packets first
	localparam int ackTimeout   = 200; // cycles, covers a held-off first word
	localparam int sumTimeout   = 400;

	logic clk;
	logic arstN;
	logic wordReq;
	logic wordLast;
	wordT wordData;
	logic wordAck;
	logic sumReq;
	wordT sumData;
	logic sumAck;

	logic [31:0] lfsr;          // galois lfsr state
	wordT        expQ[$];       // expected checksums, oldest first
	int          delayQ[$];     // sumAck delay per packet
	logic        handoffOpen;   // result handshake still in flight
	int          heldOffCycles; // cycles a first word waited on a pending result

	checksumEngine dut0 (
		.clk     (clk),
		.arstN   (arstN),
		.wordReq (wordReq),
		.wordLast(wordLast),
		.wordData(wordData),
		.wordAck (wordAck),
		.sumReq  (sumReq),
		.sumData (sumData),
		.sumAck  (sumAck)
	);

	always #50 clk = ~clk; // 100 ns period

	// one lfsr step per bit, lsb shifted out first
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return value;
	endfunction

	// integer sum mod 65535, zero only for an all-zero packet, then complemented
	function automatic wordT refChecksum(input wordT words[$]);
		longint unsigned total;
		longint unsigned folded;
		logic            anyNonZero;
		total      = 0;
		anyNonZero = 1'b0;
		foreach (words[i]) begin
			total      = total + {48'd0, words[i]};
			anyNonZero = anyNonZero | (words[i] != 16'h0000);
		end
		folded = total % 64'd65535;
		if (folded == 0 && anyNonZero) begin
			folded = 64'd65535; // negative zero
		end
		return ~folded[15:0];
	endfunction

	task automatic stopOnError();
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(input string name, input wordT got, input wordT expected);
		if (got !== expected) begin
			$display("Mismatch %s: got %h expected %h", name, got, expected);
			stopOnError();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("Mismatch %s: got %h expected %h", name, got, expected);
			stopOnError();
		end
	endtask

	// full four-phase cycle for one word
	task automatic sendWord(input wordT data, input logic last);
		int cycles;
		wordData = data;
		wordLast = last;
		wordReq  = 1'b1;
		cycles   = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (handoffOpen) begin
				checkBit("wordAck", wordAck, 1'b0); // intake must wait on busy
				heldOffCycles++;
			end
			if (cycles > ackTimeout) begin
				$display("timeout waiting for wordAck to rise");
				stopOnError();
			end
		end while (wordAck !== 1'b1);
		if (last) begin
			handoffOpen = 1'b1; // combiner busy from this edge on
		end
		wordReq = 1'b0;
		cycles  = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > ackTimeout) begin
				$display("timeout waiting for wordAck to fall");
				stopOnError();
			end
		end while (wordAck !== 1'b0);
	endtask

	task automatic sendPacket(input wordT words[$], input wordT expected);
		expQ.push_back(expected);
		delayQ.push_back(int'(randBits(4))); // 0..15 cycles of held-back ack
		foreach (words[i]) begin
			sendWord(words[i], i == words.size() - 1);
		end
	endtask

	task automatic runSource();
		wordT words[$];
		int   len;
		words = '{16'h1234};
		sendPacket(words, 16'hedcb); // single word, plain complement
		words = '{16'h0000, 16'h0000, 16'h0000};
		sendPacket(words, 16'hffff); // positive zero sum
		words = '{16'h1234, 16'hedcb};
		sendPacket(words, 16'h0000); // negative zero sum
		for (int p = 0; p < randPackets; p++) begin
			len = int'(randBits(4) % 9) + 1; // 1..9 words
			words.delete();
			for (int i = 0; i < len; i++) begin
				words.push_back(wordT'(randBits(16)));
			end
			sendPacket(words, refChecksum(words));
		end
	endtask

	// compares every offered checksum, then acks after a random delay
	task automatic runSink();
		wordT expected;
		int   delay;
		int   cycles;
		for (int p = 0; p < totalPackets; p++) begin
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
				if (cycles > sumTimeout) begin
					$display("timeout waiting for sumReq of packet %0d", p);
					stopOnError();
				end
			end while (sumReq !== 1'b1);
			if (expQ.size() == 0) begin
				$display("sumReq raised with no packet sent");
				stopOnError();
			end
			expected = expQ.pop_front();
			delay    = delayQ.pop_front();
			checkWord("sumData", sumData, expected);
			repeat (delay) begin
				@(negedge clk);
				checkBit("sumReq", sumReq, 1'b1);        // held until acked
				checkWord("sumData", sumData, expected); // stable under req
			end
			sumAck = 1'b1;
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
				if (cycles > sumTimeout) begin
					$display("timeout waiting for sumReq to fall");
					stopOnError();
				end
			end while (sumReq !== 1'b0);
			sumAck      = 1'b0;
			handoffOpen = 1'b0; // busy drops on the next edge
		end
	endtask

	initial begin
		clk           = 1'b0;
		arstN         = 1'b0;
		wordReq       = 1'b0;
		wordLast      = 1'b0;
		wordData      = '0;
		sumAck        = 1'b0;
		lfsr          = 32'hb0f4;
		handoffOpen   = 1'b0;
		heldOffCycles = 0;
		repeat (4) @(negedge clk); // reset held 4 cycles
		arstN = 1'b1;
		@(negedge clk);
		checkBit("wordAck", wordAck, 1'b0);
		checkBit("sumReq", sumReq, 1'b0);
		fork
			runSource();
			runSink();
		join
		@(negedge clk);
		checkBit("wordAck", wordAck, 1'b0); // both channels idle at the end
		checkBit("sumReq", sumReq, 1'b0);
		if (heldOffCycles == 0) begin
			$display("no first word was ever held off by a pending result");
			stopOnError();
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule
